// File: logic/wakeup_defs.svh
`ifndef WAKEUP_DEFS_SVH
`define WAKEUP_DEFS_SVH

// Integer ALU wakeup slots
`define ALU_SIZE 4
// Load pipes per register file
`define LOAD_PIPELINE 2
// FP-misc slots on the FP bus
`define FMISC_SIZE 2
`define FMA_SIZE 2

`define PREG_WIDTH 6
`define QUERY_PORTS 4

// Bus widths
`define INT_BUS_SIZE (`ALU_SIZE + `LOAD_PIPELINE)
`define FP_BUS_SIZE (`FMISC_SIZE + `FMA_SIZE)

`endif

// File: logic/wakeup_pkg.sv
`include "wakeup_defs.svh"

package wakeup_pkg;

    // Physical register index
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    // One bit per wakeup bus slot
    typedef logic [`INT_BUS_SIZE-1:0] int_mask_t;
    typedef logic [`FP_BUS_SIZE-1:0] fp_mask_t;

endpackage

// File: logic/int_wakeup_merge.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module int_wakeup_merge (
    input  logic [`ALU_SIZE-1:0]                  alu_en,
    input  logic [`ALU_SIZE-1:0]                  alu_we,
    input  wakeup_pkg::preg_t [`ALU_SIZE-1:0]     alu_rd,
    output logic [`ALU_SIZE-1:0]                  alu_ready,
    input  logic                                  csr_en,
    input  logic                                  csr_we,
    input  wakeup_pkg::preg_t                     csr_rd,
    input  logic                                  mult_en,
    input  logic                                  mult_we,
    input  wakeup_pkg::preg_t                     mult_rd,
    input  logic                                  div_en,
    input  logic                                  div_we,
    input  wakeup_pkg::preg_t                     div_rd,
    input  logic [`LOAD_PIPELINE-1:0]             load_en,
    input  logic [`LOAD_PIPELINE-1:0]             load_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_rd,
    input  logic [`LOAD_PIPELINE-1:0]             fmisc_en,
    input  logic [`LOAD_PIPELINE-1:0]             fmisc_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] fmisc_rd,
    output logic [`LOAD_PIPELINE-1:0]             fmisc_ready,
    output wakeup_pkg::int_mask_t                 bus_en,
    output wakeup_pkg::int_mask_t                 bus_we,
    output wakeup_pkg::preg_t [`INT_BUS_SIZE-1:0] bus_rd
);
    import wakeup_pkg::*;

    // Side unit that owns each ALU slot when it fires
    logic [`ALU_SIZE-1:0]  side_en;
    logic [`ALU_SIZE-1:0]  side_we;
    preg_t [`ALU_SIZE-1:0] side_rd;

    always_comb begin
        side_en = '0;
        side_we = '0;
        side_rd = '0;
        side_en[0] = csr_en;
        side_we[0] = csr_we;
        side_rd[0] = csr_rd;
        side_en[2] = mult_en;
        side_we[2] = mult_we;
        side_rd[2] = mult_rd;
        side_en[3] = div_en;
        side_we[3] = div_we;
        side_rd[3] = div_rd;
    end

    // Slot 1 has no side unit so its ready stays high
    for (genvar i = 0; i < `ALU_SIZE; i++) begin : g_alu
        assign alu_ready[i] = ~side_en[i];
        assign bus_en[i]    = side_en[i] | alu_en[i];
        assign bus_we[i]    = side_en[i] ? side_we[i] : alu_we[i];
        assign bus_rd[i]    = side_en[i] ? side_rd[i] : alu_rd[i];
    end

    // Integer loads beat FP-misc integer results
    for (genvar i = 0; i < `LOAD_PIPELINE; i++) begin : g_load
        assign fmisc_ready[i]        = ~load_en[i];
        assign bus_en[`ALU_SIZE + i] = load_en[i] | fmisc_en[i];
        assign bus_we[`ALU_SIZE + i] = load_en[i] ? load_we[i] : fmisc_we[i];
        assign bus_rd[`ALU_SIZE + i] = load_en[i] ? load_rd[i] : fmisc_rd[i];
    end

endmodule

// File: logic/fp_wakeup_merge.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module fp_wakeup_merge (
    input  logic [`LOAD_PIPELINE-1:0]             load_en,
    input  logic [`LOAD_PIPELINE-1:0]             load_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_rd,
    input  logic [`FMISC_SIZE-1:0]                fmisc_en,
    input  logic [`FMISC_SIZE-1:0]                fmisc_we,
    input  wakeup_pkg::preg_t [`FMISC_SIZE-1:0]   fmisc_rd,
    output logic [`FMISC_SIZE-1:0]                fmisc_ready,
    input  logic [`FMA_SIZE-1:0]                  fma_en,
    input  logic [`FMA_SIZE-1:0]                  fma_we,
    input  wakeup_pkg::preg_t [`FMA_SIZE-1:0]     fma_rd,
    input  logic                                  fdiv_en,
    input  logic                                  fdiv_we,
    input  wakeup_pkg::preg_t                     fdiv_rd,
    output logic                                  fdiv_ready,
    output wakeup_pkg::fp_mask_t                  bus_en,
    output wakeup_pkg::fp_mask_t                  bus_we,
    output wakeup_pkg::preg_t [`FP_BUS_SIZE-1:0]  bus_rd
);

    // Lower slots shared between FP loads and FP-misc
    for (genvar i = 0; i < `FMISC_SIZE; i++) begin : g_misc
        assign fmisc_ready[i] = ~load_en[i]; // Load wins
        assign bus_en[i]      = load_en[i] | fmisc_en[i];
        assign bus_we[i]      = load_en[i] ? load_we[i] : fmisc_we[i];
        assign bus_rd[i]      = load_en[i] ? load_rd[i] : fmisc_rd[i];
    end

    // FMA slot 0 doubles as the divider's slot
    assign fdiv_ready              = ~fma_en[0];
    assign bus_en[`FMISC_SIZE]     = fma_en[0] | fdiv_en;
    assign bus_we[`FMISC_SIZE]     = fma_en[0] ? fma_we[0] : fdiv_we;
    assign bus_rd[`FMISC_SIZE]     = fma_en[0] ? fma_rd[0] : fdiv_rd;

    for (genvar i = 1; i < `FMA_SIZE; i++) begin : g_fma
        assign bus_en[`FMISC_SIZE + i] = fma_en[i];
        assign bus_we[`FMISC_SIZE + i] = fma_we[i];
        assign bus_rd[`FMISC_SIZE + i] = fma_rd[i];
    end

endmodule

// File: logic/preg_scoreboard.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module preg_scoreboard (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  wakeup_pkg::int_mask_t                 int_bus_en,
    input  wakeup_pkg::int_mask_t                 int_bus_we,
    input  wakeup_pkg::preg_t [`INT_BUS_SIZE-1:0] int_bus_rd,
    input  wakeup_pkg::fp_mask_t                  fp_bus_en,
    input  wakeup_pkg::fp_mask_t                  fp_bus_we,
    input  wakeup_pkg::preg_t [`FP_BUS_SIZE-1:0]  fp_bus_rd,
    input  logic                                  int_alloc_en,
    input  wakeup_pkg::preg_t                     int_alloc_rd,
    input  logic                                  fp_alloc_en,
    input  wakeup_pkg::preg_t                     fp_alloc_rd,
    input  wakeup_pkg::preg_t [`QUERY_PORTS-1:0]  int_query_rd,
    input  wakeup_pkg::preg_t [`QUERY_PORTS-1:0]  fp_query_rd,
    output logic [`QUERY_PORTS-1:0]               int_query_ready,
    output logic [`QUERY_PORTS-1:0]               fp_query_ready
);

    localparam int PREG_NUM = 1 << `PREG_WIDTH;

    logic [PREG_NUM-1:0] int_ready;
    logic [PREG_NUM-1:0] int_ready_next;
    logic [PREG_NUM-1:0] fp_ready;
    logic [PREG_NUM-1:0] fp_ready_next;

    // Allocation applied last so it beats a same-cycle wakeup
    always_comb begin
        int_ready_next = int_ready;
        for (int i = 0; i < `INT_BUS_SIZE; i++) begin
            if (int_bus_en[i] && int_bus_we[i]) begin
                int_ready_next[int_bus_rd[i]] = 1'b1;
            end
        end
        if (int_alloc_en) begin
            int_ready_next[int_alloc_rd] = 1'b0;
        end
        int_ready_next[0] = 1'b1; // x0 is hardwired
    end

    always_comb begin
        fp_ready_next = fp_ready;
        for (int i = 0; i < `FP_BUS_SIZE; i++) begin
            if (fp_bus_en[i] && fp_bus_we[i]) begin
                fp_ready_next[fp_bus_rd[i]] = 1'b1;
            end
        end
        if (fp_alloc_en) begin
            fp_ready_next[fp_alloc_rd] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_ready <= '1;
            fp_ready  <= '1;
        end else begin
            int_ready <= int_ready_next;
            fp_ready  <= fp_ready_next;
        end
    end

    for (genvar q = 0; q < `QUERY_PORTS; q++) begin : g_query
        assign int_query_ready[q] = int_ready[int_query_rd[q]];
        assign fp_query_ready[q]  = fp_ready[fp_query_rd[q]];
    end

endmodule

// File: logic/wakeup_top.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module wakeup_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`ALU_SIZE-1:0]                   alu_en,
    input  logic [`ALU_SIZE-1:0]                   alu_we,
    input  wakeup_pkg::preg_t [`ALU_SIZE-1:0]      alu_rd,
    output logic [`ALU_SIZE-1:0]                   alu_ready,
    input  logic                                   csr_en,
    input  logic                                   csr_we,
    input  wakeup_pkg::preg_t                      csr_rd,
    input  logic                                   mult_en,
    input  logic                                   mult_we,
    input  wakeup_pkg::preg_t                      mult_rd,
    input  logic                                   div_en,
    input  logic                                   div_we,
    input  wakeup_pkg::preg_t                      div_rd,
    input  logic [`LOAD_PIPELINE-1:0]              load_int_en,
    input  logic [`LOAD_PIPELINE-1:0]              load_int_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_int_rd,
    input  logic [`LOAD_PIPELINE-1:0]              load_fp_en,
    input  logic [`LOAD_PIPELINE-1:0]              load_fp_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_fp_rd,
    input  logic [`LOAD_PIPELINE-1:0]              fmisc_int_en,
    input  logic [`LOAD_PIPELINE-1:0]              fmisc_int_we,
    input  wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] fmisc_int_rd,
    output logic [`LOAD_PIPELINE-1:0]              fmisc_int_ready,
    input  logic [`FMISC_SIZE-1:0]                 fmisc_fp_en,
    input  logic [`FMISC_SIZE-1:0]                 fmisc_fp_we,
    input  wakeup_pkg::preg_t [`FMISC_SIZE-1:0]    fmisc_fp_rd,
    output logic [`FMISC_SIZE-1:0]                 fmisc_fp_ready,
    input  logic [`FMA_SIZE-1:0]                   fma_en,
    input  logic [`FMA_SIZE-1:0]                   fma_we,
    input  wakeup_pkg::preg_t [`FMA_SIZE-1:0]      fma_rd,
    input  logic                                   fdiv_en,
    input  logic                                   fdiv_we,
    input  wakeup_pkg::preg_t                      fdiv_rd,
    output logic                                   fdiv_ready,
    input  logic                                   int_alloc_en,
    input  wakeup_pkg::preg_t                      int_alloc_rd,
    input  logic                                   fp_alloc_en,
    input  wakeup_pkg::preg_t                      fp_alloc_rd,
    input  wakeup_pkg::preg_t [`QUERY_PORTS-1:0]   int_query_rd,
    input  wakeup_pkg::preg_t [`QUERY_PORTS-1:0]   fp_query_rd,
    output logic [`QUERY_PORTS-1:0]                int_query_ready,
    output logic [`QUERY_PORTS-1:0]                fp_query_ready,
    output wakeup_pkg::int_mask_t                  int_wakeup_en,
    output wakeup_pkg::int_mask_t                  int_wakeup_we,
    output wakeup_pkg::preg_t [`INT_BUS_SIZE-1:0]  int_wakeup_rd,
    output wakeup_pkg::fp_mask_t                   fp_wakeup_en,
    output wakeup_pkg::fp_mask_t                   fp_wakeup_we,
    output wakeup_pkg::preg_t [`FP_BUS_SIZE-1:0]   fp_wakeup_rd
);

    int_wakeup_merge u_int_merge (
        .alu_en      (alu_en),
        .alu_we      (alu_we),
        .alu_rd      (alu_rd),
        .alu_ready   (alu_ready),
        .csr_en      (csr_en),
        .csr_we      (csr_we),
        .csr_rd      (csr_rd),
        .mult_en     (mult_en),
        .mult_we     (mult_we),
        .mult_rd     (mult_rd),
        .div_en      (div_en),
        .div_we      (div_we),
        .div_rd      (div_rd),
        .load_en     (load_int_en),
        .load_we     (load_int_we),
        .load_rd     (load_int_rd),
        .fmisc_en    (fmisc_int_en),
        .fmisc_we    (fmisc_int_we),
        .fmisc_rd    (fmisc_int_rd),
        .fmisc_ready (fmisc_int_ready),
        .bus_en      (int_wakeup_en),
        .bus_we      (int_wakeup_we),
        .bus_rd      (int_wakeup_rd)
    );

    fp_wakeup_merge u_fp_merge (
        .load_en     (load_fp_en),
        .load_we     (load_fp_we),
        .load_rd     (load_fp_rd),
        .fmisc_en    (fmisc_fp_en),
        .fmisc_we    (fmisc_fp_we),
        .fmisc_rd    (fmisc_fp_rd),
        .fmisc_ready (fmisc_fp_ready),
        .fma_en      (fma_en),
        .fma_we      (fma_we),
        .fma_rd      (fma_rd),
        .fdiv_en     (fdiv_en),
        .fdiv_we     (fdiv_we),
        .fdiv_rd     (fdiv_rd),
        .fdiv_ready  (fdiv_ready),
        .bus_en      (fp_wakeup_en),
        .bus_we      (fp_wakeup_we),
        .bus_rd      (fp_wakeup_rd)
    );

    // Scoreboard sees the same buses that leave the top
    preg_scoreboard u_scoreboard (
        .clk             (clk),
        .rst_n           (rst_n),
        .int_bus_en      (int_wakeup_en),
        .int_bus_we      (int_wakeup_we),
        .int_bus_rd      (int_wakeup_rd),
        .fp_bus_en       (fp_wakeup_en),
        .fp_bus_we       (fp_wakeup_we),
        .fp_bus_rd       (fp_wakeup_rd),
        .int_alloc_en    (int_alloc_en),
        .int_alloc_rd    (int_alloc_rd),
        .fp_alloc_en     (fp_alloc_en),
        .fp_alloc_rd     (fp_alloc_rd),
        .int_query_rd    (int_query_rd),
        .fp_query_rd     (fp_query_rd),
        .int_query_ready (int_query_ready),
        .fp_query_ready  (fp_query_ready)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: test/wakeup_props.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module wakeup_props (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic [`ALU_SIZE-1:0]                   alu_en,
    input logic [`ALU_SIZE-1:0]                   alu_we,
    input wakeup_pkg::preg_t [`ALU_SIZE-1:0]      alu_rd,
    input logic [`ALU_SIZE-1:0]                   alu_ready,
    input logic                                   csr_en,
    input logic                                   csr_we,
    input wakeup_pkg::preg_t                      csr_rd,
    input logic                                   mult_en,
    input logic                                   mult_we,
    input wakeup_pkg::preg_t                      mult_rd,
    input logic                                   div_en,
    input logic                                   div_we,
    input wakeup_pkg::preg_t                      div_rd,
    input logic [`LOAD_PIPELINE-1:0]              load_int_en,
    input logic [`LOAD_PIPELINE-1:0]              load_int_we,
    input wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_int_rd,
    input logic [`LOAD_PIPELINE-1:0]              load_fp_en,
    input logic [`LOAD_PIPELINE-1:0]              load_fp_we,
    input wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] load_fp_rd,
    input logic [`LOAD_PIPELINE-1:0]              fmisc_int_en,
    input logic [`LOAD_PIPELINE-1:0]              fmisc_int_we,
    input wakeup_pkg::preg_t [`LOAD_PIPELINE-1:0] fmisc_int_rd,
    input logic [`LOAD_PIPELINE-1:0]              fmisc_int_ready,
    input logic [`FMISC_SIZE-1:0]                 fmisc_fp_en,
    input logic [`FMISC_SIZE-1:0]                 fmisc_fp_we,
    input wakeup_pkg::preg_t [`FMISC_SIZE-1:0]    fmisc_fp_rd,
    input logic [`FMISC_SIZE-1:0]                 fmisc_fp_ready,
    input logic [`FMA_SIZE-1:0]                   fma_en,
    input logic [`FMA_SIZE-1:0]                   fma_we,
    input wakeup_pkg::preg_t [`FMA_SIZE-1:0]      fma_rd,
    input logic                                   fdiv_en,
    input logic                                   fdiv_we,
    input wakeup_pkg::preg_t                      fdiv_rd,
    input logic                                   fdiv_ready,
    input logic                                   int_alloc_en,
    input wakeup_pkg::preg_t                      int_alloc_rd,
    input logic                                   fp_alloc_en,
    input wakeup_pkg::preg_t                      fp_alloc_rd,
    input wakeup_pkg::preg_t [`QUERY_PORTS-1:0]   int_query_rd,
    input wakeup_pkg::preg_t [`QUERY_PORTS-1:0]   fp_query_rd,
    input logic [`QUERY_PORTS-1:0]                int_query_ready,
    input logic [`QUERY_PORTS-1:0]                fp_query_ready,
    input wakeup_pkg::int_mask_t                  int_wakeup_en,
    input wakeup_pkg::int_mask_t                  int_wakeup_we,
    input wakeup_pkg::preg_t [`INT_BUS_SIZE-1:0]  int_wakeup_rd,
    input wakeup_pkg::fp_mask_t                   fp_wakeup_en,
    input wakeup_pkg::fp_mask_t                   fp_wakeup_we,
    input wakeup_pkg::preg_t [`FP_BUS_SIZE-1:0]   fp_wakeup_rd
);
    import wakeup_pkg::*;

    int fail_cnt = 0; // Watched by the testbench

    int_mask_t                 exp_int_en;
    int_mask_t                 exp_int_we;
    preg_t [`INT_BUS_SIZE-1:0] exp_int_rd;
    fp_mask_t                  exp_fp_en;
    fp_mask_t                  exp_fp_we;
    preg_t [`FP_BUS_SIZE-1:0]  exp_fp_rd;
    logic [`ALU_SIZE+`LOAD_PIPELINE-1:0] exp_int_rdy;
    logic [`FMISC_SIZE:0]      exp_fp_rdy;
    logic [63:0]               int_model;
    logic [63:0]               fp_model;
    logic [`QUERY_PORTS-1:0]   exp_int_q;
    logic [`QUERY_PORTS-1:0]   exp_fp_q;

    // Reference buses built from the sharing rules
    always_comb begin
        exp_int_en = '0;
        exp_int_we = '0;
        exp_int_rd = '0;
        exp_fp_en = '0;
        exp_fp_we = '0;
        exp_fp_rd = '0;
        exp_int_en[`ALU_SIZE-1:0] = alu_en;
        exp_int_we[`ALU_SIZE-1:0] = alu_we;
        exp_int_rd[`ALU_SIZE-1:0] = alu_rd;
        exp_int_rdy = '1;
        if (csr_en)
            {exp_int_en[0], exp_int_we[0], exp_int_rd[0], exp_int_rdy[0]} =
                {1'b1, csr_we, csr_rd, 1'b0};
        if (mult_en)
            {exp_int_en[2], exp_int_we[2], exp_int_rd[2], exp_int_rdy[2]} =
                {1'b1, mult_we, mult_rd, 1'b0};
        if (div_en)
            {exp_int_en[3], exp_int_we[3], exp_int_rd[3], exp_int_rdy[3]} =
                {1'b1, div_we, div_rd, 1'b0};
        for (int i = 0; i < `LOAD_PIPELINE; i++) begin
            exp_int_rdy[`ALU_SIZE + i] = !load_int_en[i];
            if (load_int_en[i]) begin
                exp_int_en[`ALU_SIZE + i] = 1'b1;
                exp_int_we[`ALU_SIZE + i] = load_int_we[i];
                exp_int_rd[`ALU_SIZE + i] = load_int_rd[i];
            end else begin
                exp_int_en[`ALU_SIZE + i] = fmisc_int_en[i];
                exp_int_we[`ALU_SIZE + i] = fmisc_int_we[i];
                exp_int_rd[`ALU_SIZE + i] = fmisc_int_rd[i];
            end
        end
        for (int i = 0; i < `FMISC_SIZE; i++) begin
            exp_fp_rdy[i] = !load_fp_en[i];
            if (load_fp_en[i]) begin
                exp_fp_en[i] = 1'b1;
                exp_fp_we[i] = load_fp_we[i];
                exp_fp_rd[i] = load_fp_rd[i];
            end else begin
                exp_fp_en[i] = fmisc_fp_en[i];
                exp_fp_we[i] = fmisc_fp_we[i];
                exp_fp_rd[i] = fmisc_fp_rd[i];
            end
        end
        exp_fp_rdy[`FMISC_SIZE] = !fma_en[0];
        if (fma_en[0]) begin
            exp_fp_en[`FMISC_SIZE] = 1'b1;
            exp_fp_we[`FMISC_SIZE] = fma_we[0];
            exp_fp_rd[`FMISC_SIZE] = fma_rd[0];
        end else begin
            exp_fp_en[`FMISC_SIZE] = fdiv_en;
            exp_fp_we[`FMISC_SIZE] = fdiv_we;
            exp_fp_rd[`FMISC_SIZE] = fdiv_rd;
        end
        for (int i = 1; i < `FMA_SIZE; i++) begin
            exp_fp_en[`FMISC_SIZE + i] = fma_en[i];
            exp_fp_we[`FMISC_SIZE + i] = fma_we[i];
            exp_fp_rd[`FMISC_SIZE + i] = fma_rd[i];
        end
        for (int q = 0; q < `QUERY_PORTS; q++) begin
            exp_int_q[q] = int_model[int_query_rd[q]];
            exp_fp_q[q]  = fp_model[fp_query_rd[q]];
        end
    end

    // Ready model, allocation last so it wins
    always_ff @(posedge clk) begin
        logic [63:0] int_n;
        logic [63:0] fp_n;
        int_n = int_model;
        fp_n = fp_model;
        for (int i = 0; i < `INT_BUS_SIZE; i++)
            if (int_wakeup_en[i] && int_wakeup_we[i]) int_n[int_wakeup_rd[i]] = 1'b1;
        for (int i = 0; i < `FP_BUS_SIZE; i++)
            if (fp_wakeup_en[i] && fp_wakeup_we[i]) fp_n[fp_wakeup_rd[i]] = 1'b1;
        if (int_alloc_en && int_alloc_rd != '0) int_n[int_alloc_rd] = 1'b0;
        if (fp_alloc_en) fp_n[fp_alloc_rd] = 1'b0;
        if (!rst_n) begin
            int_n = '1;
            fp_n = '1;
        end
        int_model <= int_n;
        fp_model  <= fp_n;
    end

    a_int_bus: assert property (@(posedge clk) disable iff (!rst_n)
        {int_wakeup_en, int_wakeup_we, int_wakeup_rd} == {exp_int_en, exp_int_we, exp_int_rd})
        else begin
            $error("CHECK FAILED time %0t int_wakeup_en/we/rd exp %h act %h", $time,
                $sampled({exp_int_en, exp_int_we, exp_int_rd}),
                $sampled({int_wakeup_en, int_wakeup_we, int_wakeup_rd}));
            fail_cnt++;
        end

    a_int_ready: assert property (@(posedge clk) disable iff (!rst_n)
        {fmisc_int_ready, alu_ready} == exp_int_rdy)
        else begin
            $error("CHECK FAILED time %0t fmisc_int_ready/alu_ready exp %h act %h", $time,
                $sampled(exp_int_rdy), $sampled({fmisc_int_ready, alu_ready}));
            fail_cnt++;
        end

    a_fp_bus: assert property (@(posedge clk) disable iff (!rst_n)
        {fp_wakeup_en, fp_wakeup_we, fp_wakeup_rd} == {exp_fp_en, exp_fp_we, exp_fp_rd})
        else begin
            $error("CHECK FAILED time %0t fp_wakeup_en/we/rd exp %h act %h", $time,
                $sampled({exp_fp_en, exp_fp_we, exp_fp_rd}),
                $sampled({fp_wakeup_en, fp_wakeup_we, fp_wakeup_rd}));
            fail_cnt++;
        end

    a_fp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        {fdiv_ready, fmisc_fp_ready} == exp_fp_rdy)
        else begin
            $error("CHECK FAILED time %0t fdiv_ready/fmisc_fp_ready exp %h act %h", $time,
                $sampled(exp_fp_rdy), $sampled({fdiv_ready, fmisc_fp_ready}));
            fail_cnt++;
        end

    // Covers wakeup visibility, allocation and the reset state
    a_int_query: assert property (@(posedge clk) disable iff (!rst_n)
        int_query_ready == exp_int_q)
        else begin
            $error("CHECK FAILED time %0t int_query_ready exp %h act %h", $time,
                $sampled(exp_int_q), $sampled(int_query_ready));
            fail_cnt++;
        end

    a_fp_query: assert property (@(posedge clk) disable iff (!rst_n)
        fp_query_ready == exp_fp_q)
        else begin
            $error("CHECK FAILED time %0t fp_query_ready exp %h act %h", $time,
                $sampled(exp_fp_q), $sampled(fp_query_ready));
            fail_cnt++;
        end

endmodule

// File: test/wakeup_tb.sv
`timescale 1ns/1ns
`include "wakeup_defs.svh"

module wakeup_tb;
    import wakeup_pkg::*;

    localparam int CYCLES = 2000;
    localparam int PERIOD = 40;

    logic clk;
    logic rst_n;
    logic [`ALU_SIZE-1:0] alu_en, alu_we, alu_ready;
    preg_t [`ALU_SIZE-1:0] alu_rd;
    logic csr_en, csr_we, mult_en, mult_we, div_en, div_we;
    preg_t csr_rd, mult_rd, div_rd;
    logic [`LOAD_PIPELINE-1:0] load_int_en, load_int_we, load_fp_en, load_fp_we;
    preg_t [`LOAD_PIPELINE-1:0] load_int_rd, load_fp_rd, fmisc_int_rd;
    logic [`LOAD_PIPELINE-1:0] fmisc_int_en, fmisc_int_we, fmisc_int_ready;
    logic [`FMISC_SIZE-1:0] fmisc_fp_en, fmisc_fp_we, fmisc_fp_ready;
    preg_t [`FMISC_SIZE-1:0] fmisc_fp_rd;
    logic [`FMA_SIZE-1:0] fma_en, fma_we;
    preg_t [`FMA_SIZE-1:0] fma_rd;
    logic fdiv_en, fdiv_we, fdiv_ready;
    preg_t fdiv_rd;
    logic int_alloc_en, fp_alloc_en;
    preg_t int_alloc_rd, fp_alloc_rd;
    preg_t [`QUERY_PORTS-1:0] int_query_rd, fp_query_rd;
    logic [`QUERY_PORTS-1:0] int_query_ready, fp_query_ready;
    int_mask_t int_wakeup_en, int_wakeup_we;
    preg_t [`INT_BUS_SIZE-1:0] int_wakeup_rd;
    fp_mask_t fp_wakeup_en, fp_wakeup_we;
    preg_t [`FP_BUS_SIZE-1:0] fp_wakeup_rd;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clk(clk));

    wakeup_top dut (.*);

    bind wakeup_top wakeup_props u_props (.*);

    // Mostly a register announced or allocated last cycle
    function automatic preg_t recent_int_rd();
        case ($urandom_range(9))
            0, 1, 2, 3: return alu_rd[$urandom_range(3)];
            4, 5: return load_int_rd[$urandom_range(1)];
            6: return csr_rd;
            7: return int_alloc_rd;
            default: return preg_t'($urandom);
        endcase
    endfunction

    function automatic preg_t recent_fp_rd();
        case ($urandom_range(9))
            0, 1: return load_fp_rd[$urandom_range(1)];
            2, 3: return fmisc_fp_rd[$urandom_range(1)];
            4, 5: return fma_rd[$urandom_range(1)];
            6: return fdiv_rd;
            7: return fp_alloc_rd;
            default: return preg_t'($urandom);
        endcase
    endfunction

    task automatic drive_random();
        logic [127:0] r;
        logic [127:0] s;
        preg_t [`QUERY_PORTS-1:0] iq;
        preg_t [`QUERY_PORTS-1:0] fq;
        for (int q = 0; q < `QUERY_PORTS; q++) begin
            iq[q] = recent_int_rd();
            fq[q] = recent_fp_rd();
        end
        r = {$urandom, $urandom, $urandom, $urandom};
        s = {$urandom, $urandom, $urandom, $urandom};
        {alu_rd, alu_we, alu_en} <= r[31:0];
        {csr_rd, csr_we, csr_en} <= r[39:32];
        {mult_rd, mult_we, mult_en} <= r[47:40];
        {div_rd, div_we, div_en} <= r[55:48];
        {load_int_rd, load_int_we, load_int_en} <= r[71:56];
        {fmisc_int_rd, fmisc_int_we, fmisc_int_en} <= r[87:72];
        {int_alloc_rd, int_alloc_en} <= r[94:88];
        {load_fp_rd, load_fp_we, load_fp_en} <= s[15:0];
        {fmisc_fp_rd, fmisc_fp_we, fmisc_fp_en} <= s[31:16];
        {fma_rd, fma_we, fma_en} <= s[47:32];
        {fdiv_rd, fdiv_we, fdiv_en} <= s[55:48];
        {fp_alloc_rd, fp_alloc_en} <= s[62:56];
        int_query_rd <= iq;
        fp_query_rd  <= fq;
    endtask

    initial begin
        void'($urandom(32'hfa6d));
        rst_n = 1'b0;
        {alu_en, alu_we, alu_rd, csr_en, csr_we, csr_rd} = '0;
        {mult_en, mult_we, mult_rd, div_en, div_we, div_rd} = '0;
        {load_int_en, load_int_we, load_int_rd, load_fp_en, load_fp_we, load_fp_rd} = '0;
        {fmisc_int_en, fmisc_int_we, fmisc_int_rd} = '0;
        {fmisc_fp_en, fmisc_fp_we, fmisc_fp_rd, fma_en, fma_we, fma_rd} = '0;
        {fdiv_en, fdiv_we, fdiv_rd} = '0;
        {int_alloc_en, int_alloc_rd, fp_alloc_en, fp_alloc_rd} = '0;
        {int_query_rd, fp_query_rd} = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (CYCLES) begin
            @(posedge clk);
            drive_random();
        end
        // Last edge's assertions settle before the verdict
        @(posedge clk);
        @(negedge clk);
        if (dut.u_props.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "An assertion failed during the run");
        end
    end

    // Stop at the first failed assertion
    always @(dut.u_props.fail_cnt) begin
        if (dut.u_props.fail_cnt != 0) begin
            $display("sim failed");
            $fatal(1, "Assertion failure, run stopped");
        end
    end

    initial begin
        #((CYCLES + 100) * PERIOD);
        $display("sim failed");
        $fatal(1, "Watchdog expired, the run hung");
    end

endmodule

// File: wakeup.f
+incdir+logic
logic/wakeup_pkg.sv
logic/int_wakeup_merge.sv
logic/fp_wakeup_merge.sv
logic/preg_scoreboard.sv
logic/wakeup_top.sv
test/tb_clock.sv
test/wakeup_props.sv
test/wakeup_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = wakeup_tb
FILELIST = wakeup.f
OBJ_DIR  = obj_dir
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides the result, whatever the exit status of the run
sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
